/* cpu_pkg.sv */
package cpu_pkg;

    localparam int WORD   = 16;
    localparam int ADDR   = 16;
    localparam int W_OPR  = 16;
    localparam int W_RD   = 3;
    localparam int W_IMM  = 6;
    localparam int W_JOFF = 12;
    localparam int BP_IDX = 4;
    localparam int W_KIND = 3;

    localparam logic [3:0] OP_ADD  = 4'h0;
    localparam logic [3:0] OP_SUB  = 4'h1;
    localparam logic [3:0] OP_AND  = 4'h2;
    localparam logic [3:0] OP_OR   = 4'h3;
    localparam logic [3:0] OP_XOR  = 4'h4;
    localparam logic [3:0] OP_ADDI = 4'h5;
    localparam logic [3:0] OP_LD   = 4'h6;
    localparam logic [3:0] OP_ST   = 4'h7;
    localparam logic [3:0] OP_BEQ  = 4'h8;
    localparam logic [3:0] OP_BNE  = 4'h9;
    localparam logic [3:0] OP_JMP  = 4'ha;
    localparam logic [3:0] OP_HLT  = 4'hf;

    // instruction kinds seen by execute
    localparam logic [W_KIND-1:0] K_ALU = 3'd0;
    localparam logic [W_KIND-1:0] K_LD  = 3'd1;
    localparam logic [W_KIND-1:0] K_ST  = 3'd2;
    localparam logic [W_KIND-1:0] K_BR  = 3'd3;
    localparam logic [W_KIND-1:0] K_JMP = 3'd4;
    localparam logic [W_KIND-1:0] K_HLT = 3'd5;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_EQ,
        ALU_NE
    } alu_op_t;

    typedef struct packed {
        logic [3:0]      op;
        logic [W_RD-1:0] rd;
        logic [W_RD-1:0] rs;
        logic [W_RD-1:0] rt;
        logic [2:0]      spare;
    } r_fmt_t;

    typedef struct packed {
        logic [3:0]       op;
        logic [W_RD-1:0]  rd;
        logic [W_RD-1:0]  rs;
        logic [W_IMM-1:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_t;

endpackage

/* pipe_ctrl.sv */
module pipe_ctrl (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  logic                     busy_i,
    input  logic                     hlt_i,
    input  logic                     pred_taken_i,
    input  logic                     fetch_branch_i,
    input  logic                     fetch_jump_i,
    input  logic [cpu_pkg::ADDR-1:0] fetch_target_i,
    input  logic                     br_valid_i,
    input  logic                     br_taken_i,
    input  logic                     br_pred_i,
    input  logic [cpu_pkg::ADDR-1:0] br_target_i,
    input  logic [cpu_pkg::ADDR-1:0] br_pc_i,
    output logic [cpu_pkg::ADDR-1:0] pc_o,
    output logic                     take_pred_o,
    output logic                     decode_stall_o,
    output logic                     flush_o,
    output logic [cpu_pkg::ADDR-1:0] inst_addr_o
);
    import cpu_pkg::*;

    logic [ADDR-1:0] pc_q;
    logic [ADDR-1:0] pc_next;
    logic            mispredict;

    assign mispredict = br_valid_i & (br_taken_i ^ br_pred_i);

    // jumps always redirect, branches only when predicted taken
    assign take_pred_o = fetch_branch_i & pred_taken_i;

    always_comb begin
        if (mispredict) begin
            pc_next = br_taken_i ? br_target_i : br_pc_i + 1'b1;
        end else if (fetch_jump_i | take_pred_o) begin
            pc_next = fetch_target_i;
        end else begin
            pc_next = pc_q + 1'b1;
        end
    end

    // a redirect beats a dependence stall, halt freezes fetch for good
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (!stall_i && (mispredict || !(hlt_i || busy_i))) begin
            pc_q <= pc_next;
        end
    end

    assign decode_stall_o = busy_i;
    // wrong-path words in fetch and decode, or anything after halt
    assign flush_o        = mispredict | hlt_i;
    assign pc_o           = pc_q;
    assign inst_addr_o    = pc_q;

endmodule

/* fetch_stage.sv */
module fetch_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  logic                     hold_i,
    input  logic                     flush_i,
    input  logic [cpu_pkg::WORD-1:0] inst_i,
    input  logic [cpu_pkg::ADDR-1:0] pc_i,
    input  logic                     take_pred_i,
    output logic                     fd_valid_o,
    output logic [cpu_pkg::WORD-1:0] fd_inst_o,
    output logic [cpu_pkg::ADDR-1:0] fd_pc_o,
    output logic                     fd_pred_o,
    output logic                     fetch_branch_o,
    output logic                     fetch_jump_o,
    output logic [cpu_pkg::ADDR-1:0] fetch_target_o
);
    import cpu_pkg::*;

    inst_t            word;
    logic [ADDR-1:0]  offset;
    logic [W_JOFF-1:0] joff;

    assign word = inst_i;
    assign joff = {word.i_fmt.rd, word.i_fmt.rs, word.i_fmt.imm};

    assign fetch_branch_o = (word.i_fmt.op == OP_BEQ) || (word.i_fmt.op == OP_BNE);
    assign fetch_jump_o   = (word.i_fmt.op == OP_JMP);

    // targets are relative to the branch itself
    assign offset = fetch_jump_o ? {{(ADDR-W_JOFF){joff[W_JOFF-1]}}, joff}
                                 : {{(ADDR-W_IMM){word.i_fmt.imm[W_IMM-1]}}, word.i_fmt.imm};
    assign fetch_target_o = pc_i + offset;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fd_valid_o <= 1'b0;
        end else if (!stall_i) begin
            if (flush_i) begin
                fd_valid_o <= 1'b0;
            end else if (!hold_i) begin
                fd_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i && !hold_i) begin
            fd_inst_o <= inst_i;
            fd_pc_o   <= pc_i;
            fd_pred_o <= take_pred_i;
        end
    end

endmodule

/* decode_stage.sv */
module decode_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       stall_i,
    input  logic                       flush_i,
    input  logic                       fd_valid_i,
    input  logic [cpu_pkg::WORD-1:0]   fd_inst_i,
    input  logic [cpu_pkg::ADDR-1:0]   fd_pc_i,
    input  logic                       fd_pred_i,
    input  logic [cpu_pkg::W_OPR-1:0]  opr0_i,
    input  logic [cpu_pkg::W_OPR-1:0]  opr1_i,
    input  logic                       busy_i,
    output logic [cpu_pkg::W_RD-1:0]   rs_o,
    output logic [cpu_pkg::W_RD-1:0]   rt_o,
    output logic [cpu_pkg::W_RD-1:0]   rd_o,
    output logic                       reserve_o,
    output logic                       de_valid_o,
    output logic [cpu_pkg::W_OPR-1:0]  de_opr0_o,
    output logic [cpu_pkg::W_OPR-1:0]  de_opr1_o,
    output logic [cpu_pkg::W_OPR-1:0]  de_imm_o,
    output logic [cpu_pkg::ADDR-1:0]   de_pc_o,
    output cpu_pkg::alu_op_t           de_alu_op_o,
    output logic [cpu_pkg::W_RD-1:0]   de_wb_r_o,
    output logic                       de_wb_o,
    output logic [cpu_pkg::W_KIND-1:0] de_kind_o,
    output logic                       de_pred_o
);
    import cpu_pkg::*;

    inst_t             inst;
    alu_op_t           alu_op;
    logic [W_KIND-1:0] kind;
    logic              wr;
    logic              use_imm;
    logic [W_RD-1:0]   rs, rt;
    logic [W_OPR-1:0]  imm;

    assign inst = fd_inst_i;
    assign imm  = {{(W_OPR-W_IMM){inst.i_fmt.imm[W_IMM-1]}}, inst.i_fmt.imm};

    always_comb begin
        case (inst.r_fmt.op)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_BEQ:  alu_op = ALU_EQ;
            OP_BNE:  alu_op = ALU_NE;
            default: alu_op = ALU_ADD;
        endcase
    end

    // st and branches read rd as their second source
    always_comb begin
        kind    = K_JMP;
        wr      = 1'b0;
        use_imm = 1'b0;
        rs      = '0;
        rt      = '0;
        case (inst.r_fmt.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                kind = K_ALU;
                wr   = 1'b1;
                rs   = inst.r_fmt.rs;
                rt   = inst.r_fmt.rt;
            end
            OP_ADDI, OP_LD: begin
                kind    = (inst.i_fmt.op == OP_LD) ? K_LD : K_ALU;
                wr      = 1'b1;
                use_imm = 1'b1;
                rs      = inst.i_fmt.rs;
            end
            OP_ST, OP_BEQ, OP_BNE: begin
                kind = (inst.i_fmt.op == OP_ST) ? K_ST : K_BR;
                rs   = inst.i_fmt.rs;
                rt   = inst.i_fmt.rd;
            end
            OP_HLT:  kind = K_HLT;
            // jmp is handled in fetch, unknown opcodes do nothing
            default: kind = K_JMP;
        endcase
    end

    // idle indices keep a bubble from looking busy
    assign rs_o      = fd_valid_i ? rs : '0;
    assign rt_o      = fd_valid_i ? rt : '0;
    assign rd_o      = (fd_valid_i && wr) ? inst.i_fmt.rd : '0;
    assign reserve_o = fd_valid_i & wr & ~busy_i & ~flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            de_valid_o <= 1'b0;
        end else if (!stall_i) begin
            de_valid_o <= fd_valid_i & ~busy_i & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            de_opr0_o   <= opr0_i;
            de_opr1_o   <= use_imm ? imm : opr1_i;
            de_imm_o    <= imm;
            de_pc_o     <= fd_pc_i;
            de_alu_op_o <= alu_op;
            de_wb_r_o   <= inst.i_fmt.rd;
            de_wb_o     <= wr;
            de_kind_o   <= kind;
            de_pred_o   <= fd_pred_i;
        end
    end

endmodule

/* reg_file.sv */
module reg_file (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic [cpu_pkg::W_RD-1:0]  rs_i,
    input  logic [cpu_pkg::W_RD-1:0]  rt_i,
    input  logic [cpu_pkg::W_RD-1:0]  rd_i,
    input  logic                      reserve_i,
    input  logic                      wb_i,
    input  logic [cpu_pkg::W_RD-1:0]  wb_r_i,
    input  logic [cpu_pkg::W_OPR-1:0] wb_data_i,
    output logic [cpu_pkg::W_OPR-1:0] opr0_o,
    output logic [cpu_pkg::W_OPR-1:0] opr1_o,
    output logic                      busy_o
);
    import cpu_pkg::*;

    localparam int N_REG = 1 << W_RD;

    logic [W_OPR-1:0] regs [N_REG];
    logic [N_REG-1:0] resv;

    // r0 is never written and never reserved
    always_ff @(posedge clk) begin
        if (!stall_i && wb_i && wb_r_i != '0) begin
            regs[wb_r_i] <= wb_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            resv <= '0;
        end else if (!stall_i) begin
            if (wb_i) begin
                resv[wb_r_i] <= 1'b0;
            end
            // a new reservation wins over a same-cycle release
            if (reserve_i && rd_i != '0) begin
                resv[rd_i] <= 1'b1;
            end
        end
    end

    assign opr0_o = (rs_i == '0) ? '0 : regs[rs_i];
    assign opr1_o = (rt_i == '0) ? '0 : regs[rt_i];
    assign busy_o = resv[rs_i] | resv[rt_i] | resv[rd_i];

endmodule

/* exec_stage.sv */
module exec_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       stall_i,
    input  logic                       de_valid_i,
    input  logic [cpu_pkg::W_OPR-1:0]  de_opr0_i,
    input  logic [cpu_pkg::W_OPR-1:0]  de_opr1_i,
    input  logic [cpu_pkg::W_OPR-1:0]  de_imm_i,
    input  logic [cpu_pkg::ADDR-1:0]   de_pc_i,
    input  cpu_pkg::alu_op_t           de_alu_op_i,
    input  logic [cpu_pkg::W_RD-1:0]   de_wb_r_i,
    input  logic                       de_wb_i,
    input  logic [cpu_pkg::W_KIND-1:0] de_kind_i,
    input  logic                       de_pred_i,
    input  logic [cpu_pkg::W_OPR-1:0]  ldst_data_i,
    output logic [cpu_pkg::ADDR-1:0]   ldst_addr_o,
    output logic [cpu_pkg::W_OPR-1:0]  ldst_data_o,
    output logic                       ldst_write_o,
    output logic                       wb_o,
    output logic [cpu_pkg::W_RD-1:0]   wb_r_o,
    output logic [cpu_pkg::W_OPR-1:0]  wb_data_o,
    output logic                       br_valid_o,
    output logic                       br_taken_o,
    output logic                       br_pred_o,
    output logic [cpu_pkg::ADDR-1:0]   br_target_o,
    output logic [cpu_pkg::ADDR-1:0]   br_pc_o,
    output logic                       hlt_o
);
    import cpu_pkg::*;

    logic             halt_q;
    logic             v;
    logic [W_OPR-1:0] alu_res;

    // nothing executes once halted
    assign v = de_valid_i & ~halt_q;

    always_comb begin
        case (de_alu_op_i)
            ALU_SUB: alu_res = de_opr0_i - de_opr1_i;
            ALU_AND: alu_res = de_opr0_i & de_opr1_i;
            ALU_OR:  alu_res = de_opr0_i | de_opr1_i;
            ALU_XOR: alu_res = de_opr0_i ^ de_opr1_i;
            ALU_EQ:  alu_res = W_OPR'(de_opr0_i == de_opr1_i);
            ALU_NE:  alu_res = W_OPR'(de_opr0_i != de_opr1_i);
            default: alu_res = de_opr0_i + de_opr1_i;
        endcase
    end

    assign ldst_addr_o  = de_opr0_i + de_imm_i;
    assign ldst_data_o  = de_opr1_i;
    assign ldst_write_o = v & (de_kind_i == K_ST) & ~stall_i;

    assign wb_o      = v & de_wb_i;
    assign wb_r_o    = de_wb_r_i;
    assign wb_data_o = (de_kind_i == K_LD) ? ldst_data_i : alu_res;

    assign br_valid_o  = v & (de_kind_i == K_BR);
    assign br_taken_o  = alu_res[0];
    assign br_pred_o   = de_pred_i;
    assign br_target_o = de_pc_i + de_imm_i;
    assign br_pc_o     = de_pc_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            halt_q <= 1'b0;
        end else if (!stall_i && v && de_kind_i == K_HLT) begin
            halt_q <= 1'b1;
        end
    end

    assign hlt_o = halt_q;

endmodule

/* branch_pred.sv */
module branch_pred (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  logic [cpu_pkg::ADDR-1:0] pc_i,
    input  logic                     upd_i,
    input  logic [cpu_pkg::ADDR-1:0] upd_pc_i,
    input  logic                     upd_taken_i,
    output logic                     pred_taken_o
);
    import cpu_pkg::*;

    logic [1:0]        cnt [1 << BP_IDX];
    logic [BP_IDX-1:0] upd_idx;

    assign upd_idx = upd_pc_i[BP_IDX-1:0];

    // counters start weakly not taken
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < (1 << BP_IDX); i++) begin
                cnt[i] <= 2'b01;
            end
        end else if (!stall_i && upd_i) begin
            if (upd_taken_i && cnt[upd_idx] != 2'b11) begin
                cnt[upd_idx] <= cnt[upd_idx] + 2'b01;
            end else if (!upd_taken_i && cnt[upd_idx] != 2'b00) begin
                cnt[upd_idx] <= cnt[upd_idx] - 2'b01;
            end
        end
    end

    assign pred_taken_o = cnt[pc_i[BP_IDX-1:0]][1];

endmodule

/* cpu_top.sv */
module cpu_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic [cpu_pkg::WORD-1:0]  inst_i,
    output logic [cpu_pkg::ADDR-1:0]  inst_addr_o,
    input  logic [cpu_pkg::W_OPR-1:0] ldst_data_i,
    output logic [cpu_pkg::W_OPR-1:0] ldst_data_o,
    output logic [cpu_pkg::ADDR-1:0]  ldst_addr_o,
    output logic                      ldst_write_o,
    output logic                      hlt_o
);
    import cpu_pkg::*;

    // pc / fetch / predictor
    logic [ADDR-1:0]   pc;
    logic              take_pred, pred_taken;
    logic              decode_stall, flush;
    logic              fetch_branch, fetch_jump;
    logic [ADDR-1:0]   fetch_target;

    // fetch - decode
    logic              fd_valid, fd_pred;
    logic [WORD-1:0]   fd_inst;
    logic [ADDR-1:0]   fd_pc;

    // decode - register file
    logic [W_RD-1:0]   rs, rt, rd;
    logic              reserve, busy;
    logic [W_OPR-1:0]  opr0, opr1;

    // decode - execute
    logic              de_valid, de_wb, de_pred;
    logic [W_OPR-1:0]  de_opr0, de_opr1, de_imm;
    logic [ADDR-1:0]   de_pc;
    alu_op_t           de_alu_op;
    logic [W_RD-1:0]   de_wb_r;
    logic [W_KIND-1:0] de_kind;

    // execute results
    logic              wb, br_valid, br_taken, br_pred;
    logic [W_RD-1:0]   wb_r;
    logic [W_OPR-1:0]  wb_data;
    logic [ADDR-1:0]   br_target, br_pc;

    pipe_ctrl pipe_ctrl_inst (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
        .busy_i(busy), .hlt_i(hlt_o), .pred_taken_i(pred_taken),
        .fetch_branch_i(fetch_branch), .fetch_jump_i(fetch_jump),
        .fetch_target_i(fetch_target),
        .br_valid_i(br_valid), .br_taken_i(br_taken), .br_pred_i(br_pred),
        .br_target_i(br_target), .br_pc_i(br_pc),
        .pc_o(pc), .take_pred_o(take_pred), .decode_stall_o(decode_stall),
        .flush_o(flush), .inst_addr_o(inst_addr_o)
    );

    fetch_stage fetch_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
        .hold_i(decode_stall), .flush_i(flush),
        .inst_i(inst_i), .pc_i(pc), .take_pred_i(take_pred),
        .fd_valid_o(fd_valid), .fd_inst_o(fd_inst), .fd_pc_o(fd_pc), .fd_pred_o(fd_pred),
        .fetch_branch_o(fetch_branch), .fetch_jump_o(fetch_jump),
        .fetch_target_o(fetch_target)
    );

    branch_pred branch_pred_inst (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
        .pc_i(pc), .upd_i(br_valid), .upd_pc_i(br_pc), .upd_taken_i(br_taken),
        .pred_taken_o(pred_taken)
    );

    decode_stage decode_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i), .flush_i(flush),
        .fd_valid_i(fd_valid), .fd_inst_i(fd_inst), .fd_pc_i(fd_pc), .fd_pred_i(fd_pred),
        .opr0_i(opr0), .opr1_i(opr1), .busy_i(busy),
        .rs_o(rs), .rt_o(rt), .rd_o(rd), .reserve_o(reserve),
        .de_valid_o(de_valid), .de_opr0_o(de_opr0), .de_opr1_o(de_opr1),
        .de_imm_o(de_imm), .de_pc_o(de_pc), .de_alu_op_o(de_alu_op),
        .de_wb_r_o(de_wb_r), .de_wb_o(de_wb), .de_kind_o(de_kind), .de_pred_o(de_pred)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
        .rs_i(rs), .rt_i(rt), .rd_i(rd), .reserve_i(reserve),
        .wb_i(wb), .wb_r_i(wb_r), .wb_data_i(wb_data),
        .opr0_o(opr0), .opr1_o(opr1), .busy_o(busy)
    );

    exec_stage exec_stage_inst (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
        .de_valid_i(de_valid), .de_opr0_i(de_opr0), .de_opr1_i(de_opr1),
        .de_imm_i(de_imm), .de_pc_i(de_pc), .de_alu_op_i(de_alu_op),
        .de_wb_r_i(de_wb_r), .de_wb_i(de_wb), .de_kind_i(de_kind), .de_pred_i(de_pred),
        .ldst_data_i(ldst_data_i),
        .ldst_addr_o(ldst_addr_o), .ldst_data_o(ldst_data_o), .ldst_write_o(ldst_write_o),
        .wb_o(wb), .wb_r_o(wb_r), .wb_data_o(wb_data),
        .br_valid_o(br_valid), .br_taken_o(br_taken), .br_pred_o(br_pred),
        .br_target_o(br_target), .br_pc_o(br_pc), .hlt_o(hlt_o)
    );

endmodule

/* cpu_tb.sv */
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int MAX_STEPS = 4096;

    logic             clk;
    logic             rst_n;
    logic             stall;
    logic [WORD-1:0]  inst;
    logic [ADDR-1:0]  inst_addr;
    logic [W_OPR-1:0] ldst_rdata;
    logic [W_OPR-1:0] ldst_wdata;
    logic [ADDR-1:0]  ldst_addr;
    logic             ldst_write;
    logic             hlt;

    logic [WORD-1:0]  rom      [MEM_WORDS];
    logic [W_OPR-1:0] ram      [MEM_WORDS];
    logic [W_OPR-1:0] ref_mem  [MEM_WORDS];
    logic [ADDR-1:0]  exp_addr [$];
    logic [W_OPR-1:0] exp_data [$];

    integer seed;
    int     prog_len;
    int     n_store;
    int     cycles;
    int     limit;
    bit     stall_en;

    cpu_top cpu_top_inst (
        .clk(clk), .rst_n_i(rst_n), .stall_i(stall),
        .inst_i(inst), .inst_addr_o(inst_addr),
        .ldst_data_i(ldst_rdata), .ldst_data_o(ldst_wdata),
        .ldst_addr_o(ldst_addr), .ldst_write_o(ldst_write), .hlt_o(hlt)
    );

    // both memories answer in the same cycle
    assign inst       = rom[inst_addr[7:0]];
    assign ldst_rdata = ram[ldst_addr[7:0]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [WORD-1:0] r_ins(input logic [3:0] op, input int rd,
                                              input int rs, input int rt);
        return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
    endfunction

    function automatic logic [WORD-1:0] i_ins(input logic [3:0] op, input int rd,
                                              input int rs, input int imm);
        return {op, 3'(rd), 3'(rs), 6'(imm)};
    endfunction

    function automatic logic [WORD-1:0] j_ins(input int off);
        return {OP_JMP, 12'(off)};
    endfunction

    task automatic emit(input logic [WORD-1:0] w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic load_program();
        // unused words decode as halt
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = {OP_HLT, 12'(i)};
        end
        prog_len = 0;
        // alu ops on back-to-back dependences, then a write to r0
        emit(i_ins(OP_ADDI, 1, 0, 5));
        emit(i_ins(OP_ADDI, 2, 0, -3));
        emit(r_ins(OP_ADD, 3, 1, 2));
        emit(r_ins(OP_SUB, 4, 1, 2));
        emit(r_ins(OP_AND, 5, 3, 4));
        emit(r_ins(OP_OR, 6, 4, 1));
        emit(r_ins(OP_XOR, 7, 6, 2));
        emit(i_ins(OP_ADDI, 0, 1, 7));
        emit(r_ins(OP_ADD, 5, 0, 7));
        emit(i_ins(OP_ST, 3, 0, 16));
        emit(i_ins(OP_ST, 4, 0, 17));
        emit(i_ins(OP_ST, 5, 0, 18));
        emit(i_ins(OP_ST, 6, 0, 19));
        emit(i_ins(OP_ST, 7, 0, 20));
        // counted loop, six passes
        emit(i_ins(OP_ADDI, 1, 0, 0));
        emit(i_ins(OP_ADDI, 2, 0, 6));
        emit(i_ins(OP_ADDI, 1, 1, 1));
        emit(r_ins(OP_ADD, 3, 3, 1));
        emit(i_ins(OP_ST, 3, 1, 20));
        emit(i_ins(OP_BEQ, 0, 1, 4));
        emit(i_ins(OP_BNE, 2, 1, -4));
        emit(i_ins(OP_BEQ, 2, 1, 2));
        emit(i_ins(OP_ST, 1, 0, 30));
        emit(j_ins(2));
        emit(i_ins(OP_ST, 2, 0, 31));
        // loads of random data, combined and stored back
        emit(i_ins(OP_LD, 4, 0, 0));
        emit(i_ins(OP_LD, 5, 0, 1));
        emit(r_ins(OP_ADD, 6, 4, 5));
        emit(r_ins(OP_XOR, 7, 6, 4));
        emit(i_ins(OP_ST, 6, 0, 8));
        emit(i_ins(OP_ST, 7, 0, 9));
        emit({OP_HLT, 12'h000});
        // must never reach memory
        emit(i_ins(OP_ST, 1, 0, 10));
    endtask

    // instruction-level interpreter, returns the number of executed instructions
    function automatic int run_ref();
        logic [W_OPR-1:0] r [8];
        logic [ADDR-1:0]  pc;
        logic [ADDR-1:0]  nxt;
        logic [WORD-1:0]  w;
        logic [W_OPR-1:0] a;
        logic [W_OPR-1:0] b;
        logic [W_OPR-1:0] sx;
        logic [W_OPR-1:0] ea;
        int               n;
        ref_mem = ram;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        pc = '0;
        n  = 0;
        while (n < MAX_STEPS) begin
            w   = rom[pc[7:0]];
            a   = r[w[8:6]];
            b   = r[w[5:3]];
            sx  = {{10{w[5]}}, w[5:0]};
            ea  = a + sx;
            nxt = pc + 16'd1;
            n++;
            case (w[15:12])
                OP_ADD:  r[w[11:9]] = a + b;
                OP_SUB:  r[w[11:9]] = a - b;
                OP_AND:  r[w[11:9]] = a & b;
                OP_OR:   r[w[11:9]] = a | b;
                OP_XOR:  r[w[11:9]] = a ^ b;
                OP_ADDI: r[w[11:9]] = ea;
                OP_LD:   r[w[11:9]] = ref_mem[ea[7:0]];
                OP_ST: begin
                    ref_mem[ea[7:0]] = r[w[11:9]];
                    exp_addr.push_back(ea);
                    exp_data.push_back(r[w[11:9]]);
                end
                OP_BEQ:  if (a == r[w[11:9]]) nxt = pc + sx;
                OP_BNE:  if (a != r[w[11:9]]) nxt = pc + sx;
                OP_JMP:  nxt = pc + {{4{w[11]}}, w[11:0]};
                OP_HLT:  return n;
                default: ;
            endcase
            r[0] = '0;
            pc   = nxt;
        end
        return n;
    endfunction

    // one store per unstalled execute cycle
    always @(negedge clk) begin
        if (rst_n && ldst_write === 1'b1) begin
            if (n_store >= exp_addr.size()) begin
                $display("store to address %h after the expected sequence had ended", ldst_addr);
                $display("Simulation failed");
                $fatal(1, "unexpected store");
            end else begin
                check_val(ldst_addr, exp_addr[n_store], "store address");
                check_val(ldst_wdata, exp_data[n_store], "store data");
                ram[ldst_addr[7:0]] = ldst_wdata;
                n_store++;
            end
        end
    end

    always @(posedge clk) begin
        #2;
        stall = stall_en && (($random(seed) & 3) == 0);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run timed out after %0d cycles without reaching halt", cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic run_program(input bit with_stall);
        int n_ref;
        logic [ADDR-1:0] halt_addr;
        @(negedge clk);
        stall_en = with_stall;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = W_OPR'($random(seed));
        end
        n_ref   = run_ref();
        limit   = 40 * n_ref + 200;
        n_store = 0;
        @(posedge clk);
        #2 rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        cycles = 0;
        while (hlt !== 1'b1) begin
            @(negedge clk);
        end
        // fetch stays frozen once halted
        halt_addr = inst_addr;
        repeat (20) begin
            @(negedge clk);
            check_val(32'(hlt), 32'd1, "hlt_o after halt");
            check_val(inst_addr, halt_addr, "fetch address after halt");
        end
        check_val(n_store, exp_addr.size(), "store count");
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_val(ram[i], ref_mem[i], $sformatf("data memory word %0d", i));
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        stall    = 1'b0;
        stall_en = 1'b0;
        seed     = 68;
        limit    = 1000;
        cycles   = 0;
        n_store  = 0;
        load_program();
        run_program(1'b0);
        // same program again under random stall_i
        run_program(1'b1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* src.f */
cpu_pkg.sv
pipe_ctrl.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
exec_stage.sv
branch_pred.sv
cpu_top.sv
cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
